// ==== project.f ====
hw/mipsIsaPkg.sv
hw/mipsCtrlPkg.sv
hw/instrDecoder.sv
hw/alu.sv
hw/registerFile.sv
hw/pcUnit.sv
hw/singleCycleMips.sv
verification/singleCycleMips_chk.sv
verification/singleCycleMipsTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the single-cycle MIPS testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module singleCycleMipsTb \
  --Mdir obj_dir \
  -f project.f
if [ $? -ne 0 ]; then
  echo "verilator compile step returned an error"
  exit 1
fi

./obj_dir/VsingleCycleMipsTb
status=$?
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit $status
fi
exit 0

// ==== verification/singleCycleMipsTb.sv ====
// testbench for the single-cycle MIPS32 subset core
// ROM and SRAM models, program table and an architectural reference model
`timescale 1ns/1ps
`default_nettype none

module singleCycleMipsTb
  import mipsIsaPkg::*;
();

  localparam logic [31:0] resetPc       = 32'd0;
  localparam int          dataAddrWidth = 7;
  // word 57 is a j to itself
  localparam logic [31:0] haltPc        = 32'd228;
  localparam int          maxCycles     = 200;

  logic        clk;
  logic        rst;
  instrWord    ir;
  logic [31:0] readDataMem;
  logic [31:0] irAddr;
  logic [31:0] rfWriteData;
  logic        cen;
  logic        wen;
  logic [6:0]  addr;
  logic [31:0] writeData;

  // memory models
  logic [31:0] rom [0:63];
  logic [31:0] preload [0:127];
  logic [31:0] sram [0:127];
  // reference model state
  logic [31:0] mRegs [0:31];
  logic [31:0] mMem [0:127];
  logic [31:0] mPc;
  integer      seed;
  int          cycles;

  singleCycleMips #(
    .resetPc       (resetPc),
    .dataAddrWidth (dataAddrWidth)
  ) dut (
    .clk         (clk),
    .rst         (rst),
    .ir          (ir),
    .readDataMem (readDataMem),
    .irAddr      (irAddr),
    .rfWriteData (rfWriteData),
    .cen         (cen),
    .wen         (wen),
    .addr        (addr),
    .writeData   (writeData)
  );

  always #5 clk = ~clk;

  // ==========================================================================
  // memory models
  // ==========================================================================
  // ROM answers from the word at irAddr / 4
  assign ir = rom[irAddr[7:2]];

  always_comb begin
    readDataMem = (!cen && wen) ? sram[addr] : 32'd0;
  end

  // random image loaded in reset and clocked writes after
  always_ff @(posedge clk) begin
    if (!rst) begin
      for (int i = 0; i < 128; i++) begin
        sram[i] <= preload[i];
      end
    end else if (!cen && !wen) begin
      sram[addr] <= writeData;
    end
  end

  // ==========================================================================
  // instruction encoding and program table
  // ==========================================================================
  function automatic logic [31:0] encodeR(input logic [5:0] funct, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd);
    return {opRType, rs, rt, rd, 5'd0, funct};
  endfunction

  function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] encodeJ(input logic [5:0] op, input logic [25:0] target);
    return {op, target};
  endfunction

  task automatic buildProgram();
    for (int i = 0; i < 64; i++) begin
      rom[i] = 32'd0;
    end
    // random operands with r4 equal to r1
    rom[0]  = encodeI(opLw, 5'd0, 5'd1, 16'd0);
    rom[1]  = encodeI(opLw, 5'd0, 5'd2, 16'd4);
    rom[2]  = encodeI(opLw, 5'd0, 5'd3, 16'd8);
    rom[3]  = encodeI(opLw, 5'd0, 5'd4, 16'd0);
    rom[4]  = encodeR(fnAdd, 5'd1, 5'd2, 5'd5);
    rom[5]  = encodeR(fnSub, 5'd1, 5'd2, 5'd6);
    rom[6]  = encodeR(fnAnd, 5'd1, 5'd3, 5'd7);
    rom[7]  = encodeR(fnOr, 5'd2, 5'd3, 5'd8);
    // slt both ways then equal operands
    rom[8]  = encodeR(fnSlt, 5'd1, 5'd2, 5'd9);
    rom[9]  = encodeR(fnSlt, 5'd2, 5'd1, 5'd10);
    rom[10] = encodeR(fnSlt, 5'd1, 5'd4, 5'd11);
    rom[11] = encodeR(fnAdd, 5'd1, 5'd2, 5'd0);
    // store then reload the same word
    rom[12] = encodeI(opSw, 5'd0, 5'd5, 16'd12);
    rom[13] = encodeI(opLw, 5'd0, 5'd12, 16'd12);
    rom[14] = encodeI(opBeq, 5'd1, 5'd2, 16'd5);
    // forward taken branch skips 16 and 17
    rom[15] = encodeI(opBeq, 5'd1, 5'd4, 16'd2);
    rom[16] = encodeR(fnAdd, 5'd1, 5'd1, 5'd13);
    rom[17] = encodeR(fnAdd, 5'd1, 5'd1, 5'd13);
    // unknown opcode then unknown funct
    rom[18] = encodeI(6'h3f, 5'd1, 5'd2, 16'h1234);
    rom[19] = encodeR(6'h3f, 5'd1, 5'd2, 5'd14);
    rom[20] = encodeJ(opJal, 26'd23);
    rom[21] = encodeR(fnAdd, 5'd1, 5'd1, 5'd14);
    rom[22] = encodeJ(opJ, 26'd25);
    rom[23] = encodeR(fnAdd, 5'd2, 5'd2, 5'd15);
    // backward branch to word 22
    rom[24] = encodeI(opBeq, 5'd0, 5'd0, 16'hfffd);
    // register dump into words 96..127
    for (int r = 0; r < 32; r++) begin
      rom[25 + r] = encodeI(opSw, 5'd0, 5'(r), 16'(384 + 4 * r));
    end
    rom[57] = encodeJ(opJ, 26'd57);
  endtask

  // ==========================================================================
  // checks and reference model
  // ==========================================================================
  task automatic abortRun();
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("MISMATCH %s expected 0x%h actual 0x%h", name, expected, actual);
      abortRun();
    end
  endtask

  // model runs one instruction and compares the DUT before commit
  task automatic checkAndStep();
    instrWord    w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sImm;
    logic [31:0] res;
    logic [31:0] nextPc;
    logic [6:0]  wordIdx;
    logic [4:0]  dst;
    logic        expCen;
    logic        expWen;
    logic        doWrite;
    w       = rom[mPc[7:2]];
    a       = mRegs[w.rType.rs];
    b       = mRegs[w.rType.rt];
    sImm    = {{16{w.iType.imm[15]}}, w.iType.imm};
    wordIdx = 7'((a + sImm) >> 2);
    nextPc  = mPc + 32'd4;
    res     = 32'd0;
    dst     = w.rType.rd;
    expCen  = 1'b1;
    expWen  = 1'b1;
    doWrite = 1'b1;
    case (w.rType.opcode)
      opRType: begin
        case (w.rType.funct)
          fnAdd:   res = a + b;
          fnSub:   res = a - b;
          fnAnd:   res = a & b;
          fnOr:    res = a | b;
          fnSlt:   res = (a < b) ? 32'd1 : 32'd0;
          default: doWrite = 1'b0;
        endcase
      end
      opLw: begin
        res    = mMem[wordIdx];
        dst    = w.iType.rt;
        expCen = 1'b0;
      end
      opSw: begin
        expCen  = 1'b0;
        expWen  = 1'b0;
        doWrite = 1'b0;
      end
      opBeq: begin
        doWrite = 1'b0;
        if (a == b) begin
          nextPc = nextPc + (sImm << 2);
        end
      end
      opJ: begin
        doWrite = 1'b0;
        nextPc  = {nextPc[31:28], w.jType.target, 2'b00};
      end
      opJal: begin
        res    = mPc + 32'd8;
        dst    = linkReg;
        nextPc = {nextPc[31:28], w.jType.target, 2'b00};
      end
      default: doWrite = 1'b0;
    endcase
    checkValue("irAddr", mPc, irAddr);
    checkValue("cen", 32'(expCen), 32'(cen));
    checkValue("wen", 32'(expWen), 32'(wen));
    if (doWrite) begin
      checkValue("rfWriteData", res, rfWriteData);
    end
    if (!expCen) begin
      checkValue("addr", 32'(wordIdx), 32'(addr));
    end
    if (!expWen) begin
      checkValue("writeData", b, writeData);
    end
    // commit while r0 stays zero
    if (doWrite && dst != 5'd0) begin
      mRegs[dst] = res;
    end
    if (!expWen) begin
      mMem[wordIdx] = b;
    end
    mPc = nextPc;
  endtask

  // ==========================================================================
  // main sequence
  // ==========================================================================
  initial begin
    clk  = 1'b0;
    rst  = 1'b1;
    seed = 32'he744;
    for (int i = 0; i < 128; i++) begin
      preload[i] = $random(seed);
      mMem[i]    = preload[i];
    end
    for (int i = 0; i < 32; i++) begin
      mRegs[i] = 32'd0;
    end
    mPc = resetPc;
    buildProgram();
    @(negedge clk);
    rst = 1'b0;
    // three cycles in reset with idle strobes
    for (int i = 0; i < 3; i++) begin
      @(negedge clk);
      checkValue("irAddr", resetPc, irAddr);
      checkValue("cen", 32'd1, 32'(cen));
      checkValue("wen", 32'd1, 32'(wen));
    end
    rst = 1'b1;
    #1;
    cycles = 0;
    while (mPc != haltPc) begin
      if (cycles >= maxCycles) begin
        $display("timeout: halt address not reached within %0d cycles", maxCycles);
        abortRun();
      end
      checkAndStep();
      cycles++;
      @(negedge clk);
    end
    // whole SRAM including the register dump
    for (int i = 0; i < 128; i++) begin
      checkValue($sformatf("sram[%0d]", i), mMem[i], sram[i]);
    end
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verification/singleCycleMips_chk.sv ====
// bound checks for the single-cycle core
// SRAM strobe rules, reset state and PC alignment
`timescale 1ns/1ps
`default_nettype none

module singleCycleMips_chk #(
  parameter logic [31:0] resetPc = 32'd0
) (
  input logic        clk,
  input logic        rst,
  input logic        cen,
  input logic        wen,
  input logic [31:0] irAddr
);

  // a write strobe needs the chip enable
  writeNeedsEnable: assert property (@(posedge clk) !wen |-> !cen)
    else $error("wen low while cen high");

  idleInReset: assert property (@(posedge clk) !rst |-> (cen && wen))
    else $error("memory strobe active during reset");

  // byte address of a word
  pcAligned: assert property (@(posedge clk) irAddr[1:0] == 2'b00)
    else $error("irAddr not word aligned");

  pcAtReset: assert property (@(posedge clk) !rst |-> irAddr == resetPc)
    else $error("irAddr differs from reset address during reset");

endmodule

bind singleCycleMips singleCycleMips_chk #(
  .resetPc (resetPc)
) uChk (
  .clk    (clk),
  .rst    (rst),
  .cen    (cen),
  .wen    (wen),
  .irAddr (irAddr)
);

`default_nettype wire

// ==== hw/singleCycleMips.sv ====
// single-cycle MIPS32 subset core, top level
// instruction ROM port, data SRAM port with active-low cen and wen
`timescale 1ns/1ps
`default_nettype none

module singleCycleMips
  import mipsIsaPkg::*;
  import mipsCtrlPkg::*;
#(
  parameter logic [31:0] resetPc       = 32'd0,
  parameter int          dataAddrWidth = 7
) (
  input  logic                     clk,
  input  logic                     rst,
  input  instrWord                 ir,
  input  logic [31:0]              readDataMem,
  output logic [31:0]              irAddr,
  output logic [31:0]              rfWriteData,
  output logic                     cen,
  output logic                     wen,
  output logic [dataAddrWidth-1:0] addr,
  output logic [31:0]              writeData
);

  ctrlWord     ctrl;
  aluOpE       aluOp;
  logic [31:0] rdData1;
  logic [31:0] rdData2;
  logic [31:0] immExt;
  logic [31:0] aluB;
  logic [31:0] aluResult;
  logic        aluZero;
  logic [31:0] linkAddr;
  logic [4:0]  wrDest;
  logic        rfWe;

  // ==========================================================================
  // decode and operands
  // ==========================================================================
  instrDecoder uDecoder (
    .instr (ir),
    .ctrl  (ctrl),
    .aluOp (aluOp)
  );

  assign immExt = {{16{ir.iType.imm[15]}}, ir.iType.imm};
  assign aluB   = ctrl.aluSrc ? immExt : rdData2;

  // held off in reset
  assign rfWe = rst && ctrl.valid && ctrl.regWrite;

  // jal forces r31
  assign wrDest = ctrl.link   ? linkReg :
                  ctrl.regDst ? ir.rType.rd : ir.rType.rt;

  registerFile uRegFile (
    .clk     (clk),
    .rst     (rst),
    .we      (rfWe),
    .rdAddr1 (ir.rType.rs),
    .rdAddr2 (ir.rType.rt),
    .wrAddr  (wrDest),
    .wrData  (rfWriteData),
    .rdData1 (rdData1),
    .rdData2 (rdData2)
  );

  alu uAlu (
    .a      (rdData1),
    .b      (aluB),
    .op     (aluOp),
    .result (aluResult),
    .zero   (aluZero)
  );

  pcUnit #(
    .resetPc (resetPc)
  ) uPc (
    .clk      (clk),
    .rst      (rst),
    .branch   (ctrl.branch),
    .jump     (ctrl.jump),
    .zero     (aluZero),
    .imm      (ir.iType.imm),
    .target   (ir.jType.target),
    .pc       (irAddr),
    .linkAddr (linkAddr)
  );

  // ==========================================================================
  // writeback and data SRAM
  // ==========================================================================
  // link, then load data, then ALU
  assign rfWriteData = ctrl.link     ? linkAddr    :
                       ctrl.memToReg ? readDataMem : aluResult;

  // strobes idle high while in reset
  assign cen = !rst || !(ctrl.memRead || ctrl.memWrite);
  assign wen = !rst || !ctrl.memWrite;

  // word address from byte address
  assign addr      = aluResult[dataAddrWidth+1:2];
  assign writeData = rdData2;

endmodule

`default_nettype wire

// ==== hw/pcUnit.sv ====
// program counter with sequential, branch and jump next-PC
// also gives pc + 8 for jal
`timescale 1ns/1ps
`default_nettype none

module pcUnit #(
  parameter logic [31:0] resetPc = 32'd0
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        branch,
  input  logic        jump,
  input  logic        zero,
  input  logic [15:0] imm,
  input  logic [25:0] target,
  output logic [31:0] pc,
  output logic [31:0] linkAddr
);

  logic [31:0] pcPlus4;
  logic [31:0] branchOffset;
  logic [31:0] branchAddr;
  logic [31:0] jumpAddr;
  logic [31:0] nextPc;

  assign pcPlus4 = pc + 32'd4;

  // sign-extended word offset, in bytes
  assign branchOffset = {{14{imm[15]}}, imm, 2'b00};
  assign branchAddr   = pcPlus4 + branchOffset;

  // region bits from pc + 4
  assign jumpAddr = {pcPlus4[31:28], target, 2'b00};

  // jump wins, then taken beq, else fall through
  always_comb begin
    if (jump) begin
      nextPc = jumpAddr;
    end else if (branch && zero) begin
      nextPc = branchAddr;
    end else begin
      nextPc = pcPlus4;
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= resetPc;
    end else begin
      pc <= nextPc;
    end
  end

  // no delay slot, but the link value keeps the MIPS pc + 8 rule
  assign linkAddr = pc + 32'd8;

endmodule

`default_nettype wire

// ==== hw/registerFile.sv ====
// 32 x 32 register file, r0 hardwired to zero
// two combinational read ports, one clocked write port
`timescale 1ns/1ps
`default_nettype none

module registerFile (
  input  logic        clk,
  input  logic        rst,
  input  logic        we,
  input  logic [4:0]  rdAddr1,
  input  logic [4:0]  rdAddr2,
  input  logic [4:0]  wrAddr,
  input  logic [31:0] wrData,
  output logic [31:0] rdData1,
  output logic [31:0] rdData2
);

  // no storage behind r0
  logic [31:0] regs [1:31];

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && wrAddr != 5'd0) begin
      regs[wrAddr] <= wrData;
    end
  end

  // ==========================================================================
  // read ports
  // ==========================================================================
  // r0 reads zero, writes to it are dropped above
  assign rdData1 = (rdAddr1 == 5'd0) ? 32'd0 : regs[rdAddr1];
  assign rdData2 = (rdAddr2 == 5'd0) ? 32'd0 : regs[rdAddr2];

endmodule

`default_nettype wire

// ==== hw/alu.sv ====
// 32-bit ALU: add, sub, and, or, unsigned slt
// zero flag raised for any all-zero result
`timescale 1ns/1ps
`default_nettype none

module alu
  import mipsCtrlPkg::*;
(
  input  logic [31:0] a,
  input  logic [31:0] b,
  input  aluOpE       op,
  output logic [31:0] result,
  output logic        zero
);

  always_comb begin
    case (op)
      aluAdd: result = a + b;
      aluSub: result = a - b;
      aluAnd: result = a & b;
      aluOr:  result = a | b;
      // unsigned compare, one in bit 0
      aluSlt: result = {31'd0, (a < b)};
      default: result = a + b;
    endcase
  end

  // beq qualification happens in pcUnit
  assign zero = (result == 32'd0);

endmodule

`default_nettype wire

// ==== hw/instrDecoder.sv ====
// main control decode and ALU operation decode
// opcode gives the control word and ALU class, funct refines R-type
`timescale 1ns/1ps
`default_nettype none

module instrDecoder
  import mipsIsaPkg::*;
  import mipsCtrlPkg::*;
(
  input  instrWord instr,
  output ctrlWord  ctrl,
  output aluOpE    aluOp
);

  ctrlWord  mainCtrl;
  aluClassE aluClass;
  logic     functOk;

  // ==========================================================================
  // opcode decode
  // ==========================================================================
  always_comb begin
    mainCtrl = '0;
    aluClass = clsMem;
    case (instr.rType.opcode)
      opRType: begin
        mainCtrl.regDst   = 1'b1;
        mainCtrl.regWrite = 1'b1;
        mainCtrl.valid    = 1'b1;
        aluClass          = clsRType;
      end
      opLw: begin
        mainCtrl.aluSrc   = 1'b1;
        mainCtrl.memToReg = 1'b1;
        mainCtrl.regWrite = 1'b1;
        mainCtrl.memRead  = 1'b1;
        mainCtrl.valid    = 1'b1;
      end
      opSw: begin
        mainCtrl.aluSrc   = 1'b1;
        mainCtrl.memWrite = 1'b1;
        mainCtrl.valid    = 1'b1;
      end
      opBeq: begin
        // compare by subtraction
        mainCtrl.branch = 1'b1;
        mainCtrl.valid  = 1'b1;
        aluClass        = clsBranch;
      end
      opJ: begin
        mainCtrl.jump  = 1'b1;
        mainCtrl.valid = 1'b1;
      end
      opJal: begin
        mainCtrl.jump     = 1'b1;
        mainCtrl.link     = 1'b1;
        mainCtrl.regWrite = 1'b1;
        mainCtrl.valid    = 1'b1;
      end
      // anything else stays all-zero, a no-op
      default: begin
        mainCtrl = '0;
      end
    endcase
  end

  // ==========================================================================
  // ALU operation from class and funct
  // ==========================================================================
  always_comb begin
    aluOp   = aluAdd;
    functOk = 1'b1;
    case (aluClass)
      clsBranch: aluOp = aluSub;
      clsRType: begin
        case (instr.rType.funct)
          fnAdd:   aluOp = aluAdd;
          fnSub:   aluOp = aluSub;
          fnAnd:   aluOp = aluAnd;
          fnOr:    aluOp = aluOr;
          fnSlt:   aluOp = aluSlt;
          default: functOk = 1'b0;
        endcase
      end
      // lw, sw address add; j and jal don't care
      default: aluOp = aluAdd;
    endcase
  end

  // unknown funct turns the R-type into a no-op
  assign ctrl = (aluClass == clsRType && !functOk) ? ctrlWord'('0) : mainCtrl;

endmodule

`default_nettype wire

// ==== hw/mipsCtrlPkg.sv ====
// datapath control types for the single-cycle core
// control word from the decoder, ALU operation and ALU class
`default_nettype none

package mipsCtrlPkg;

  // ==========================================================================
  // ALU
  // ==========================================================================
  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluSlt
  } aluOpE;

  // coarse class from the opcode, refined by funct for R-type
  typedef enum logic [1:0] {
    clsMem,
    clsBranch,
    clsRType
  } aluClassE;

  // ==========================================================================
  // main control word
  // ==========================================================================
  typedef struct packed {
    // rd instead of rt as destination
    logic regDst;
    // sign-extended immediate as ALU operand b
    logic aluSrc;
    logic memToReg;
    logic regWrite;
    logic memRead;
    logic memWrite;
    logic branch;
    logic jump;
    // jal, write link address into r31
    logic link;
    logic valid;
  } ctrlWord;

endpackage

`default_nettype wire

// ==== hw/mipsIsaPkg.sv ====
// MIPS32 subset instruction set definitions
// opcode and funct codes, plus the R/I/J views of one instruction word
`default_nettype none

package mipsIsaPkg;

  // ==========================================================================
  // opcode field values
  // ==========================================================================
  localparam logic [5:0] opRType = 6'b000000;
  localparam logic [5:0] opLw    = 6'b100011;
  localparam logic [5:0] opSw    = 6'b101011;
  localparam logic [5:0] opBeq   = 6'b000100;
  localparam logic [5:0] opJ     = 6'b000010;
  localparam logic [5:0] opJal   = 6'b000011;

  // funct field values, R-type only
  localparam logic [5:0] fnAdd = 6'b100000;
  localparam logic [5:0] fnSub = 6'b100010;
  localparam logic [5:0] fnAnd = 6'b100100;
  localparam logic [5:0] fnOr  = 6'b100101;
  localparam logic [5:0] fnSlt = 6'b101010;

  // jal destination
  localparam logic [4:0] linkReg = 5'd31;

  // ==========================================================================
  // instruction word views
  // ==========================================================================
  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } rTypeFields;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } iTypeFields;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [25:0] target;
  } jTypeFields;

  // same 32 bits, read three ways
  typedef union packed {
    rTypeFields rType;
    iTypeFields iType;
    jTypeFields jType;
  } instrWord;

endpackage

`default_nettype wire
